// ==== l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache
#(
	parameter int ADDR_BITS = l2_geom_pkg::ADDR_BITS,
	parameter int LINE_BITS = l2_geom_pkg::LINE_BITS,
	parameter int SET_BITS = l2_geom_pkg::SET_BITS,
	parameter int WAYS = l2_geom_pkg::WAYS
)
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                mem_read,
	input  logic                                mem_write,
	input  logic [ADDR_BITS-1:0]                mem_address,
	input  logic [LINE_BITS-1:0]                mem_wdata,
	input  logic                                pmem_resp,
	input  logic [LINE_BITS-1:0]                pmem_rdata,
	output logic                                mem_resp,
	output logic [LINE_BITS-1:0]                mem_rdata,
	output logic                                pmem_read,
	output logic                                pmem_write,
	output logic [ADDR_BITS-1:0]                pmem_address,
	output logic [LINE_BITS-1:0]                pmem_wdata,
	output logic [l2_ctrl_pkg::COUNT_BITS-1:0] miss_count
);

	localparam int TAG_BITS = ADDR_BITS - SET_BITS - l2_geom_pkg::OFFSET_BITS;
	localparam int WAY_BITS = $clog2(WAYS);

	logic addr_reg_load, write_enable, valid_in, dirty_datain;
	logic datain_mux_sel, cache_allocate, pmem_address_sel, evict_allocate;
	logic cache_hit, dirtyout;
	logic [SET_BITS-1:0]            set_index;
	logic [TAG_BITS-1:0]            line_tag;
	logic [WAY_BITS-1:0]            victim_way;
	logic [WAYS-1:0]                way_we, way_hit, way_dirty;
	logic [WAYS-1:0][TAG_BITS-1:0]  way_tag;
	logic [WAYS-1:0][LINE_BITS-1:0] way_line;
	logic [LINE_BITS-1:0]           line_in;

	l2_cache_control i_ctrl (.clk, .rst, .mem_read, .mem_write, .pmem_resp, .cache_hit,
		.dirtyout, .pmem_read, .pmem_write, .mem_resp, .datain_mux_sel, .write_enable,
		.valid_in, .dirty_datain, .cache_allocate, .pmem_address_sel, .addr_reg_load,
		.evict_allocate, .miss_count);

	l2_victim_select #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS), .WAYS(WAYS)) i_feed (
		.clk, .rst, .mem_address, .addr_reg_load, .write_enable, .evict_allocate,
		.cache_allocate, .way_hit, .mem_resp, .set_index, .line_tag, .victim_way, .way_we);

	////////////////////////////////////////////////////////////////////////////
	// the ways see the same index, tag and fill data. Only the write strobe differs.
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < WAYS; g++)
	begin : g_way
		l2_way #(.ADDR_BITS(ADDR_BITS), .LINE_BITS(LINE_BITS), .SET_BITS(SET_BITS)) i_way (
			.clk, .rst, .set_index, .line_tag, .we(way_we[g]), .valid_in, .dirty_datain,
			.line_in, .hit(way_hit[g]), .dirty(way_dirty[g]), .tag(way_tag[g]),
			.line(way_line[g]));
	end

	l2_hit_merge #(.ADDR_BITS(ADDR_BITS), .LINE_BITS(LINE_BITS), .SET_BITS(SET_BITS),
		.WAYS(WAYS)) i_drain (
		.way_hit, .way_dirty, .way_tag, .way_line, .victim_way, .set_index, .line_tag,
		.pmem_address_sel, .datain_mux_sel, .mem_wdata, .pmem_rdata, .cache_hit, .dirtyout,
		.mem_rdata, .line_in, .pmem_address, .pmem_wdata);

endmodule

// ==== l2_cache_control.sv ====
`timescale 1ns/1ps

module l2_cache_control
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                mem_read,
	input  logic                                mem_write,
	input  logic                                pmem_resp,
	input  logic                                cache_hit,
	input  logic                                dirtyout,
	output logic                                pmem_read,
	output logic                                pmem_write,
	output logic                                mem_resp,
	output logic                                datain_mux_sel,
	output logic                                write_enable,
	output logic                                valid_in,
	output logic                                dirty_datain,
	output logic                                cache_allocate,
	output logic                                pmem_address_sel,
	output logic                                addr_reg_load,
	output logic                                evict_allocate,
	output logic [l2_ctrl_pkg::COUNT_BITS-1:0] miss_count
);

	l2_ctrl_pkg::ctrl_state_t state;
	l2_ctrl_pkg::ctrl_state_t next_state;

	////////////////////////////////////////////////////////////////////////////
	// state outputs.
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin : state_actions
		datain_mux_sel = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		write_enable = 1'b0;
		valid_in = 1'b0;
		mem_resp = 1'b0;
		cache_allocate = 1'b0;
		dirty_datain = 1'b0;
		pmem_address_sel = 1'b0;
		evict_allocate = 1'b0;
		case (state)
			l2_ctrl_pkg::HIT:
			begin
				if (cache_hit && (mem_read || mem_write))
				begin
					mem_resp = 1'b1; // the array read is combinational, so the hit answers now.
					if (mem_write)
					begin
						// a write hit replaces the whole line and marks it dirty.
						write_enable = 1'b1;
						valid_in = 1'b1;
						dirty_datain = 1'b1;
						datain_mux_sel = 1'b1;
					end
				end
			end
			l2_ctrl_pkg::EVICT:
			begin
				evict_allocate = 1'b1;
				pmem_address_sel = 1'b1; // write back to the victim's own address.
				pmem_write = 1'b1;
			end
			l2_ctrl_pkg::ALLOCATE:
			begin
				evict_allocate = 1'b1;
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					write_enable = 1'b1;
					valid_in = 1'b1;
					cache_allocate = 1'b1; // the filled line arrives clean.
				end
			end
			default:
			begin
			end
		endcase
	end

	always_comb
	begin : next_state_logic
		next_state = state;
		addr_reg_load = 1'b0;
		case (state)
			l2_ctrl_pkg::HIT:
			begin
				if (!cache_hit && (mem_read || mem_write))
				begin
					addr_reg_load = 1'b1;
					next_state = dirtyout ? l2_ctrl_pkg::EVICT : l2_ctrl_pkg::ALLOCATE;
				end
			end
			l2_ctrl_pkg::EVICT:
			begin
				if (pmem_resp)
					next_state = l2_ctrl_pkg::ALLOCATE;
			end
			l2_ctrl_pkg::ALLOCATE:
			begin
				if (pmem_resp)
					next_state = l2_ctrl_pkg::HIT; // the retried request now hits.
			end
			default:
				next_state = l2_ctrl_pkg::HIT;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= l2_ctrl_pkg::HIT;
			miss_count <= '0;
		end
		else
		begin
			state <= next_state;
			// count each miss once, on the way into allocate.
			if ((next_state == l2_ctrl_pkg::ALLOCATE) && (state != l2_ctrl_pkg::ALLOCATE))
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

// ==== l2_cache_props.sv ====
`timescale 1ns/1ps

module l2_cache_props
#(
	parameter int ADDR_BITS = l2_geom_pkg::ADDR_BITS
)
(
	input logic                 clk,
	input logic                 rst,
	input logic                 mem_read,
	input logic                 mem_write,
	input logic                 mem_resp,
	input logic                 pmem_read,
	input logic                 pmem_write,
	input logic                 pmem_resp,
	input logic [ADDR_BITS-1:0] pmem_address
);

	// the memory port carries one transfer at a time.
	a_one_pmem_op: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	a_pmem_addr_stable: assert property (@(posedge clk) disable iff (rst)
		((pmem_read || pmem_write) && !pmem_resp) |=> $stable(pmem_address))
		else $error("pmem_address changed while a request was held");

	a_resp_with_req: assert property (@(posedge clk) disable iff (rst)
		mem_resp |-> (mem_read || mem_write))
		else $error("mem_resp without a client request");

	a_idle_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !(pmem_read || pmem_write))
		else $error("memory request right after reset");

endmodule

bind l2_cache l2_cache_props #(.ADDR_BITS(ADDR_BITS)) i_props (.clk(clk), .rst(rst),
	.mem_read(mem_read), .mem_write(mem_write), .mem_resp(mem_resp), .pmem_read(pmem_read),
	.pmem_write(pmem_write), .pmem_resp(pmem_resp), .pmem_address(pmem_address));

// ==== l2_cache_tb.sv ====
`timescale 1ns/1ps

module l2_cache_tb;

	localparam int LINE_BITS = 64;
	localparam int ADDR_BITS = l2_geom_pkg::ADDR_BITS;
	localparam int SET_BITS = l2_geom_pkg::SET_BITS;
	localparam int OFFSET_BITS = l2_geom_pkg::OFFSET_BITS;
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;
	localparam int SETS = 1 << SET_BITS;
	localparam int NUM_ROWS = 17;
	localparam int CLK_PERIOD = 10;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 40;

	typedef struct packed
	{
		logic                 wr;
		logic [ADDR_BITS-1:0] addr;
		logic [LINE_BITS-1:0] wdata;
	} row_t;

	// one client operation per row. Write flag, byte address, write data.
	localparam row_t ROWS [NUM_ROWS] = '{
		'{1'b0, 32'h0000_1044, 64'h0}, // set 2 misses and fills from the aligned line.
		'{1'b0, 32'h0000_105c, 64'h0},
		'{1'b1, 32'h0000_1040, 64'hdead_beef_0123_4567},
		'{1'b0, 32'h0000_2040, 64'h0},
		'{1'b0, 32'h0000_3040, 64'h0}, // second conflict pushes the dirty line out.
		'{1'b0, 32'h0000_1040, 64'h0},
		'{1'b0, 32'h0000_3040, 64'h0},
		'{1'b0, 32'h0000_1040, 64'h0},
		'{1'b0, 32'h0000_5040, 64'h0}, // a third tag takes the older way.
		'{1'b0, 32'h0000_1048, 64'h0}, // the more recent line is still resident.
		'{1'b1, 32'h0000_00a0, 64'h1111_2222_3333_4444},
		'{1'b1, 32'h1000_00a0, 64'h5555_6666_7777_8888},
		'{1'b1, 32'h2000_00a0, 64'h9999_aaaa_bbbb_cccc},
		'{1'b0, 32'h0000_00a0, 64'h0},
		'{1'b0, 32'h1000_00a4, 64'h0},
		'{1'b1, 32'hffff_ffe0, 64'h0f0f_0f0f_f0f0_f0f0},
		'{1'b0, 32'hffff_ffe8, 64'h0}
	};

	logic clk = 1'b0;
	logic rst, mem_read, mem_write, mem_resp, pmem_read, pmem_write, pmem_resp;
	logic [ADDR_BITS-1:0] mem_address, pmem_address;
	logic [LINE_BITS-1:0] mem_wdata, mem_rdata, pmem_rdata, pmem_wdata;
	logic [l2_ctrl_pkg::COUNT_BITS-1:0] miss_count;

	// reference model of the two ways, the LRU pointer and the backing memory.
	logic [LINE_BITS-1:0] ref_line [SETS][2];
	logic [TAG_BITS-1:0]  ref_tag [SETS][2];
	bit                   ref_valid [SETS][2];
	bit                   ref_dirty [SETS][2];
	bit                   ref_lru [SETS];
	logic [LINE_BITS-1:0] ref_mem [logic [ADDR_BITS-1:0]];
	logic [LINE_BITS-1:0] mem_lines [logic [ADDR_BITS-1:0]];
	logic [ADDR_BITS-1:0] exp_fill_addr [$];
	logic [ADDR_BITS-1:0] exp_wb_addr [$];
	logic [LINE_BITS-1:0] exp_wb_data [$];
	logic [LINE_BITS-1:0] exp_rdata;
	int errors = 0;
	int checks = 0;
	int exp_misses = 0;
	int pmem_reqs, exp_reqs;

	always #(CLK_PERIOD / 2) clk = ~clk;

	l2_cache #(.LINE_BITS(LINE_BITS)) i_dut (.clk, .rst, .mem_read, .mem_write, .mem_address,
		.mem_wdata, .pmem_resp, .pmem_rdata, .mem_resp, .mem_rdata, .pmem_read, .pmem_write,
		.pmem_address, .pmem_wdata, .miss_count);

	// memory contents before any write-back.
	function automatic logic [LINE_BITS-1:0] init_line(logic [ADDR_BITS-1:0] a);
		return {a ^ 32'h5a5a_0000, a * 32'h9e37_79b1};
	endfunction

	task automatic check_value(string name, logic [LINE_BITS-1:0] got, logic [LINE_BITS-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model stepped once per row before the request is driven.
	////////////////////////////////////////////////////////////////////////////

	task automatic predict(input row_t r);
		logic [SET_BITS-1:0]  set;
		logic [TAG_BITS-1:0]  tag;
		logic [ADDR_BITS-1:0] base, wb;
		int                   way;
		bit                   hit;
		set = r.addr[OFFSET_BITS +: SET_BITS];
		tag = r.addr[ADDR_BITS-1 -: TAG_BITS];
		base = {tag, set, {OFFSET_BITS{1'b0}}};
		hit = 1'b0;
		way = 0;
		exp_reqs = 0;
		for (int w = 0; w < 2; w++)
			if (ref_valid[set][w] && ref_tag[set][w] == tag)
			begin
				hit = 1'b1;
				way = w;
			end
		if (!hit)
		begin
			way = ref_lru[set];
			if (ref_valid[set][way] && ref_dirty[set][way])
			begin
				wb = {ref_tag[set][way], set, {OFFSET_BITS{1'b0}}};
				ref_mem[wb] = ref_line[set][way];
				exp_wb_addr.push_back(wb);
				exp_wb_data.push_back(ref_line[set][way]);
				exp_reqs++;
			end
			exp_fill_addr.push_back(base);
			ref_line[set][way] = ref_mem.exists(base) ? ref_mem[base] : init_line(base);
			ref_tag[set][way] = tag;
			ref_valid[set][way] = 1'b1;
			ref_dirty[set][way] = 1'b0;
			exp_reqs++;
			exp_misses++;
		end
		exp_rdata = ref_line[set][way];
		if (r.wr)
		begin
			ref_line[set][way] = r.wdata;
			ref_dirty[set][way] = 1'b1;
		end
		ref_lru[set] = (way == 0); // the other way becomes the victim.
	endtask

	task automatic run_row(input row_t r);
		logic [LINE_BITS-1:0] got_rdata;
		predict(r);
		pmem_reqs = 0;
		@(negedge clk);
		mem_read = ~r.wr;
		mem_write = r.wr;
		mem_address = r.addr;
		mem_wdata = r.wdata;
		do
			@(posedge clk);
		while (!mem_resp);
		got_rdata = mem_rdata;
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
		check_value("pmem requests", pmem_reqs, exp_reqs);
		if (!r.wr)
			check_value("mem_rdata", got_rdata, exp_rdata);
	endtask

	// line memory that answers each held request after a random delay.
	initial
	begin : memory_model
		int                   delay;
		logic [ADDR_BITS-1:0] a;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever
		begin
			@(negedge clk);
			if (!rst && (pmem_read || pmem_write))
			begin
				pmem_reqs++;
				delay = $urandom_range(6, 0);
				repeat (delay) @(negedge clk);
				a = pmem_address;
				checks++;
				if (pmem_write)
				begin
					assert (exp_wb_addr.size() > 0)
					else
					begin
						$display("unexpected write-back to memory at %0t", $time);
						errors++;
					end
					if (exp_wb_addr.size() > 0)
					begin
						check_value("pmem_address", a, exp_wb_addr.pop_front());
						check_value("pmem_wdata", pmem_wdata, exp_wb_data.pop_front());
					end
					mem_lines[a] = pmem_wdata;
				end
				else
				begin
					assert (exp_fill_addr.size() > 0)
					else
					begin
						$display("unexpected line read from memory at %0t", $time);
						errors++;
					end
					if (exp_fill_addr.size() > 0)
						check_value("pmem_address", a, exp_fill_addr.pop_front());
					pmem_rdata = mem_lines.exists(a) ? mem_lines[a] : init_line(a);
				end
				pmem_resp = 1'b1;
				@(negedge clk);
				pmem_resp = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, a request never completed", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial
	begin : main
		void'($urandom(24));
		rst = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(ROWS[i]);
		repeat (2) @(negedge clk);
		checks++;
		assert (exp_fill_addr.size() == 0 && exp_wb_addr.size() == 0)
		else
		begin
			$display("memory transfers predicted by the model never took place");
			errors++;
		end
		check_value("miss_count", miss_count, exp_misses);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== l2_ctrl_pkg.sv ====
package l2_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// controller encoding.
	////////////////////////////////////////////////////////////////////////////

	// hit also serves as the idle state while no request is pending.
	typedef enum logic [1:0]
	{
		HIT,
		EVICT,
		ALLOCATE
	} ctrl_state_t;

	parameter int COUNT_BITS = 32; // width of the miss counter.

endpackage

// ==== l2_geom_pkg.sv ====
package l2_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// cache geometry defaults.
	////////////////////////////////////////////////////////////////////////////

	// byte address presented by the client and sent to memory.
	parameter int ADDR_BITS = 32;

	// a line covers 32 bytes of address space.
	parameter int OFFSET_BITS = 5;

	parameter int LINE_BITS = 256; // one whole line moves per transfer.

	// eight sets by default.
	parameter int SET_BITS = 3;

	parameter int WAYS = 2; // the LRU scheme is exact for two ways.

	// the tag is whatever remains of the address above index and offset.
	// Each module derives it from the widths above.

endpackage

// ==== l2_hit_merge.sv ====
`timescale 1ns/1ps

module l2_hit_merge
#(
	parameter int ADDR_BITS = l2_geom_pkg::ADDR_BITS,
	parameter int LINE_BITS = l2_geom_pkg::LINE_BITS,
	parameter int SET_BITS = l2_geom_pkg::SET_BITS,
	parameter int WAYS = l2_geom_pkg::WAYS,
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - l2_geom_pkg::OFFSET_BITS,
	localparam int WAY_BITS = $clog2(WAYS)
)
(
	input  logic [WAYS-1:0]                way_hit,
	input  logic [WAYS-1:0]                way_dirty,
	input  logic [WAYS-1:0][TAG_BITS-1:0]  way_tag,
	input  logic [WAYS-1:0][LINE_BITS-1:0] way_line,
	input  logic [WAY_BITS-1:0]            victim_way,
	input  logic [SET_BITS-1:0]            set_index,
	input  logic [TAG_BITS-1:0]            line_tag,
	input  logic                           pmem_address_sel,
	input  logic                           datain_mux_sel,
	input  logic [LINE_BITS-1:0]           mem_wdata,
	input  logic [LINE_BITS-1:0]           pmem_rdata,
	output logic                           cache_hit,
	output logic                           dirtyout,
	output logic [LINE_BITS-1:0]           mem_rdata,
	output logic [LINE_BITS-1:0]           line_in,
	output logic [ADDR_BITS-1:0]           pmem_address,
	output logic [LINE_BITS-1:0]           pmem_wdata
);

	logic [TAG_BITS-1:0] addr_tag;

	assign cache_hit = |way_hit;

	// at most one way matches, so an and-or mux picks its line.
	always_comb
	begin
		mem_rdata = '0;
		for (int w = 0; w < WAYS; w++)
			mem_rdata |= {LINE_BITS{way_hit[w]}} & way_line[w];
	end

	assign dirtyout = way_dirty[victim_way];
	assign pmem_wdata = way_line[victim_way];

	assign addr_tag = pmem_address_sel ? way_tag[victim_way] : line_tag; // victim on evict.
	assign pmem_address = {addr_tag, set_index, {l2_geom_pkg::OFFSET_BITS{1'b0}}};

	assign line_in = datain_mux_sel ? mem_wdata : pmem_rdata;

endmodule

// ==== l2_victim_select.sv ====
`timescale 1ns/1ps

module l2_victim_select
#(
	parameter int ADDR_BITS = l2_geom_pkg::ADDR_BITS,
	parameter int SET_BITS = l2_geom_pkg::SET_BITS,
	parameter int WAYS = l2_geom_pkg::WAYS,
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - l2_geom_pkg::OFFSET_BITS,
	localparam int WAY_BITS = $clog2(WAYS),
	localparam int SETS = 1 << SET_BITS
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [ADDR_BITS-1:0] mem_address,
	input  logic                 addr_reg_load,
	input  logic                 write_enable,
	input  logic                 evict_allocate,
	input  logic                 cache_allocate,
	input  logic [WAYS-1:0]      way_hit,
	input  logic                 mem_resp,
	output logic [SET_BITS-1:0]  set_index,
	output logic [TAG_BITS-1:0]  line_tag,
	output logic [WAY_BITS-1:0]  victim_way,
	output logic [WAYS-1:0]      way_we
);

	logic [ADDR_BITS-1:0]           miss_address;
	logic [ADDR_BITS-1:0]           cur_address;
	logic [SETS-1:0][WAY_BITS-1:0] lru;
	logic [WAY_BITS-1:0]            hit_way;

	always_ff @(posedge clk)
	begin
		if (addr_reg_load)
			miss_address <= mem_address;
	end

	// the miss phases work on the latched address.
	assign cur_address = evict_allocate ? miss_address : mem_address;
	assign set_index = cur_address[l2_geom_pkg::OFFSET_BITS +: SET_BITS];
	assign line_tag = cur_address[ADDR_BITS-1 -: TAG_BITS];

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++)
			if (way_hit[w])
				hit_way = WAY_BITS'(w);
	end

	assign victim_way = lru[set_index];

	// a hit writes the matching way. A fill writes the victim.
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			way_we[w] = write_enable & (evict_allocate ?
				(cache_allocate & (victim_way == WAY_BITS'(w))) : way_hit[w]);
	end

	// with two ways the pointer names the way not used last.
	always_ff @(posedge clk)
	begin
		if (rst)
			lru <= '0;
		else if (mem_resp)
			lru[set_index] <= (hit_way == WAY_BITS'(WAYS - 1)) ? '0 : hit_way + 1'b1;
	end

endmodule

// ==== l2_way.sv ====
`timescale 1ns/1ps

module l2_way
#(
	parameter int ADDR_BITS = l2_geom_pkg::ADDR_BITS,
	parameter int LINE_BITS = l2_geom_pkg::LINE_BITS,
	parameter int SET_BITS = l2_geom_pkg::SET_BITS,
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - l2_geom_pkg::OFFSET_BITS,
	localparam int SETS = 1 << SET_BITS
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [SET_BITS-1:0]  set_index,
	input  logic [TAG_BITS-1:0]  line_tag,
	input  logic                 we,
	input  logic                 valid_in,
	input  logic                 dirty_datain,
	input  logic [LINE_BITS-1:0] line_in,
	output logic                 hit,
	output logic                 dirty,
	output logic [TAG_BITS-1:0]  tag,
	output logic [LINE_BITS-1:0] line
);

	logic [SETS-1:0]      valid_arr;
	logic [SETS-1:0]      dirty_arr;
	logic [TAG_BITS-1:0]  tag_arr [SETS];
	logic [LINE_BITS-1:0] line_arr [SETS];

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_arr <= '0;
		else if (we)
			valid_arr[set_index] <= valid_in;
	end

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			dirty_arr[set_index] <= dirty_datain;
			tag_arr[set_index] <= line_tag;
			line_arr[set_index] <= line_in;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// combinational read of the addressed set.
	////////////////////////////////////////////////////////////////////////////

	assign tag = tag_arr[set_index];
	assign line = line_arr[set_index];

	// an empty set never reports dirty, so it is never written back.
	assign dirty = valid_arr[set_index] & dirty_arr[set_index];
	assign hit = valid_arr[set_index] && (tag_arr[set_index] == line_tag);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the l2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module l2_cache_tb -f sources.f

out=$(./obj_dir/Vl2_cache_tb)
echo "$out"

echo "$out" | grep -qx "all tests passed"

// ==== sources.f ====
l2_geom_pkg.sv
l2_ctrl_pkg.sv
l2_cache_control.sv
l2_victim_select.sv
l2_way.sv
l2_hit_merge.sv
l2_cache.sv
l2_cache_props.sv
l2_cache_tb.sv
